//--- include/hbmc_defs.svh
`ifndef HBMC_DEFS_SVH
`define HBMC_DEFS_SVH

// AXI4 slave port geometry
`define HBMC_AXI_DATA_WIDTH   32
`define HBMC_AXI_ADDR_WIDTH   32
`define HBMC_AXI_ID_WIDTH     4

// 16-bit words per byte lane for 2 KiB in total
`define HBMC_LANE_ADDR_WIDTH  10

// 32-entry data FIFOs
`define HBMC_FIFO_DEPTH_LOG2  5

// pending write-packet counter
`define HBMC_PKT_CNT_WIDTH    12

`endif

//--- logic/hbmc_pkg.sv
`default_nettype none

`include "hbmc_defs.svh"

package hbmc_pkg;

    typedef logic [`HBMC_AXI_ADDR_WIDTH-1:0]   axi_addr_t;
    typedef logic [`HBMC_AXI_DATA_WIDTH-1:0]   axi_data_t;
    typedef logic [`HBMC_AXI_DATA_WIDTH/8-1:0] axi_strb_t;
    typedef logic [`HBMC_AXI_ID_WIDTH-1:0]     axi_id_t;
    typedef logic [7:0]                        axi_len_t;
    typedef logic [1:0]                        axi_burst_t;

    typedef logic [31:0] mem_addr_t;   // 16-bit word address
    typedef logic [15:0] word_cnt_t;
    typedef logic [15:0] mem_word_t;

    typedef enum logic [1:0] {XFER_RST, XFER_SEL, XFER_INIT, XFER_RUN} xfer_state_e;
    typedef enum logic {BRESP_IDLE, BRESP_SEND} bresp_state_e;

    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;
    localparam axi_burst_t BURST_WRAP  = 2'b10;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- logic/hbmc_byte_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbmc_defs.svh"

module hbmc_byte_lane (
    input  logic                             s_axi_aclk,
    input  logic [`HBMC_LANE_ADDR_WIDTH-1:0] addr,
    input  logic                             we,
    input  logic [7:0]                       wdata,
    output logic [7:0]                       rdata
);

    logic [7:0] mem [0:(1 << `HBMC_LANE_ADDR_WIDTH)-1];

    always_ff @(posedge s_axi_aclk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // registered read returns old data on a write
    end

endmodule

`default_nettype wire

//--- logic/hbmc_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbmc_defs.svh"

module hbmc_sync_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             s_axi_aclk,
    input  logic             s_axi_areset,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int AW    = `HBMC_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    logic [WIDTH-1:0] mem [0:DEPTH-1];
    logic [AW-1:0]    wr_ptr, rd_ptr;
    logic [AW:0]      count;   // one extra bit to tell full from empty
    logic             do_push, do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign full    = (count == (AW + 1)'(DEPTH));
    assign empty   = (count == '0);
    assign dout    = mem[rd_ptr];   // show-ahead

    always_ff @(posedge s_axi_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge s_axi_aclk or posedge s_axi_areset) begin
        if (s_axi_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/hbmc_word_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbmc_defs.svh"

module hbmc_word_engine (
    input  logic                                  s_axi_aclk,
    input  logic                                  s_axi_areset,
    input  logic                                  cmd_req,
    input  hbmc_pkg::mem_addr_t                   cmd_mem_addr,
    input  hbmc_pkg::word_cnt_t                   cmd_word_cnt,
    input  logic                                  cmd_wr_not_rd,
    input  logic                                  cmd_wrap_not_incr,
    output logic                                  cmd_ack,
    input  logic [`HBMC_AXI_DATA_WIDTH*9/8-1:0]   dfifo_dout,
    input  logic                                  dfifo_empty,
    output logic                                  dfifo_pop,
    output logic [`HBMC_AXI_DATA_WIDTH:0]         ufifo_din,
    input  logic                                  ufifo_full,
    output logic                                  ufifo_push,
    output logic [`HBMC_LANE_ADDR_WIDTH-1:0]      lane_addr,
    output logic [1:0]                            lane_we,
    output hbmc_pkg::mem_word_t                   lane_wdata,
    input  hbmc_pkg::mem_word_t                   lane_rdata
);

    hbmc_pkg::mem_addr_t cur_addr, addr_inc, wrap_mask, next_addr;
    hbmc_pkg::word_cnt_t remaining;
    hbmc_pkg::mem_word_t lo_word;   // first word of a read beat

    logic active, start, word_go, last_word, hi_half;
    logic rd_vld, rd_hi, rd_last;

    assign hi_half   = cur_addr[0];   // odd word is the upper half of a beat
    assign last_word = (remaining == 16'd1);
    assign start     = cmd_req & ~active & ~cmd_ack;

    // reads hold back the second word until the beat has room
    assign word_go = active && remaining != '0 &&
                     (cmd_wr_not_rd ? !dfifo_empty : (!hi_half || !ufifo_full));

    assign addr_inc  = cur_addr + 32'd1;
    assign wrap_mask = hbmc_pkg::mem_addr_t'(cmd_word_cnt) - 32'd1;
    assign next_addr = cmd_wrap_not_incr ? ((cur_addr & ~wrap_mask) | (addr_inc & wrap_mask))
                                         : addr_inc;

    assign lane_addr  = cur_addr[`HBMC_LANE_ADDR_WIDTH-1:0];   // aliases modulo 2 KiB
    assign lane_wdata = hi_half ? dfifo_dout[35:20] : dfifo_dout[19:4];
    assign lane_we    = (word_go && cmd_wr_not_rd) ?
                        (hi_half ? dfifo_dout[3:2] : dfifo_dout[1:0]) : 2'b00;
    assign dfifo_pop  = word_go & cmd_wr_not_rd & hi_half;

    assign ufifo_push = rd_vld & rd_hi;
    assign ufifo_din  = {rd_last, lane_rdata, lo_word};

    always_ff @(posedge s_axi_aclk or posedge s_axi_areset) begin
        if (s_axi_areset) begin
            active    <= 1'b0;
            cmd_ack   <= 1'b0;
            remaining <= '0;
            rd_vld    <= 1'b0;
        end else begin
            cmd_ack <= 1'b0;
            if (start) begin
                active    <= 1'b1;
                remaining <= cmd_word_cnt;
            end else if (word_go) begin
                remaining <= remaining - 16'd1;
            end
            if ((word_go && cmd_wr_not_rd && last_word) || (ufifo_push && rd_last)) begin
                active  <= 1'b0;
                cmd_ack <= 1'b1;   // single-cycle completion
            end
            rd_vld <= word_go & ~cmd_wr_not_rd;   // lane data valid next cycle
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (start) begin
            cur_addr <= cmd_mem_addr;
        end else if (word_go) begin
            cur_addr <= next_addr;
        end
        if (word_go) begin
            rd_hi   <= hi_half;
            rd_last <= last_word;
        end
        if (rd_vld && !rd_hi) begin
            lo_word <= lane_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/hbmc_axi_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbmc_defs.svh"

module hbmc_axi_front (
    input  logic                 s_axi_aclk,
    input  logic                 s_axi_areset,
    input  hbmc_pkg::axi_id_t    s_axi_awid,
    input  hbmc_pkg::axi_addr_t  s_axi_awaddr,
    input  hbmc_pkg::axi_len_t   s_axi_awlen,
    input  hbmc_pkg::axi_burst_t s_axi_awburst,
    input  logic                 s_axi_awvalid,
    output logic                 s_axi_awready,
    input  logic                 s_axi_wvalid,
    input  logic                 s_axi_wready,
    input  logic                 s_axi_wlast,
    output hbmc_pkg::axi_id_t    s_axi_bid,
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,
    input  hbmc_pkg::axi_id_t    s_axi_arid,
    input  hbmc_pkg::axi_addr_t  s_axi_araddr,
    input  hbmc_pkg::axi_len_t   s_axi_arlen,
    input  hbmc_pkg::axi_burst_t s_axi_arburst,
    input  logic                 s_axi_arvalid,
    output logic                 s_axi_arready,
    output hbmc_pkg::axi_id_t    s_axi_rid,
    output logic [1:0]           s_axi_rresp,
    input  logic                 s_axi_rlast,
    input  logic                 s_axi_rvalid,
    input  logic                 s_axi_rready,
    output logic                 cmd_req,
    output hbmc_pkg::mem_addr_t  cmd_mem_addr,
    output hbmc_pkg::word_cnt_t  cmd_word_cnt,
    output logic                 cmd_wr_not_rd,
    output logic                 cmd_wrap_not_incr,
    input  logic                 cmd_ack
);

    hbmc_pkg::xfer_state_e  xfer_state;
    hbmc_pkg::bresp_state_e bresp_state;

    logic [`HBMC_PKT_CNT_WIDTH-1:0] wr_pkt_cnt;
    logic rd_busy;   // read burst still draining
    logic wr_addr_done, wr_data_done, wr_resp_done, rd_addr_done, rd_data_done;
    logic wr_cond, rd_cond, take_wr, take_rd;

    hbmc_pkg::axi_addr_t  sel_addr;
    hbmc_pkg::axi_len_t   sel_len;
    hbmc_pkg::axi_burst_t sel_burst;

    assign wr_addr_done = s_axi_awvalid & s_axi_awready;
    assign wr_data_done = s_axi_wvalid & s_axi_wready & s_axi_wlast;
    assign wr_resp_done = s_axi_bvalid & s_axi_bready;
    assign rd_addr_done = s_axi_arvalid & s_axi_arready;
    assign rd_data_done = s_axi_rvalid & s_axi_rready & s_axi_rlast;

    assign wr_cond = s_axi_awvalid && bresp_state == hbmc_pkg::BRESP_IDLE && wr_pkt_cnt != '0;
    assign rd_cond = s_axi_arvalid & ~rd_busy;

    // serve the other direction than last time when both are pending
    assign take_wr = wr_cond & (~rd_cond | ~cmd_wr_not_rd);
    assign take_rd = rd_cond & ~take_wr;

    assign sel_addr  = take_wr ? s_axi_awaddr  : s_axi_araddr;
    assign sel_len   = take_wr ? s_axi_awlen   : s_axi_arlen;
    assign sel_burst = take_wr ? s_axi_awburst : s_axi_arburst;

    assign s_axi_bresp = hbmc_pkg::RESP_OKAY;
    assign s_axi_rresp = hbmc_pkg::RESP_OKAY;

    always_ff @(posedge s_axi_aclk or posedge s_axi_areset) begin
        if (s_axi_areset) begin
            xfer_state    <= hbmc_pkg::XFER_RST;
            cmd_req       <= 1'b0;
            cmd_wr_not_rd <= 1'b0;
            s_axi_awready <= 1'b0;
            s_axi_arready <= 1'b0;
        end else begin
            case (xfer_state)
                hbmc_pkg::XFER_RST: begin
                    xfer_state <= hbmc_pkg::XFER_SEL;
                end
                hbmc_pkg::XFER_SEL: begin
                    if (take_wr || take_rd) begin
                        s_axi_awready <= take_wr;   // one-cycle address accept
                        s_axi_arready <= take_rd;
                        cmd_wr_not_rd <= take_wr;
                        xfer_state    <= hbmc_pkg::XFER_INIT;
                    end
                end
                hbmc_pkg::XFER_INIT: begin
                    s_axi_awready <= 1'b0;
                    s_axi_arready <= 1'b0;
                    cmd_req       <= 1'b1;
                    xfer_state    <= hbmc_pkg::XFER_RUN;
                end
                hbmc_pkg::XFER_RUN: begin
                    if (cmd_ack) begin
                        cmd_req    <= 1'b0;
                        xfer_state <= hbmc_pkg::XFER_SEL;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (xfer_state == hbmc_pkg::XFER_SEL && (take_wr || take_rd)) begin
            // 4-byte aligned byte address to word address
            cmd_mem_addr      <= hbmc_pkg::mem_addr_t'({sel_addr[`HBMC_AXI_ADDR_WIDTH-1:2], 1'b0});
            cmd_word_cnt      <= (hbmc_pkg::word_cnt_t'(sel_len) + 16'd1) << 1;
            cmd_wrap_not_incr <= (sel_burst == hbmc_pkg::BURST_WRAP);
            if (take_wr) begin
                s_axi_bid <= s_axi_awid;
            end else begin
                s_axi_rid <= s_axi_arid;
            end
        end
    end

    always_ff @(posedge s_axi_aclk or posedge s_axi_areset) begin
        if (s_axi_areset) begin
            rd_busy <= 1'b0;
        end else if (rd_addr_done) begin
            rd_busy <= 1'b1;
        end else if (rd_data_done) begin
            rd_busy <= 1'b0;
        end
    end

    // complete W packets sitting in the downstream FIFO
    always_ff @(posedge s_axi_aclk or posedge s_axi_areset) begin
        if (s_axi_areset) begin
            wr_pkt_cnt <= '0;
        end else if (wr_data_done && !wr_resp_done) begin
            wr_pkt_cnt <= wr_pkt_cnt + 1'b1;
        end else if (wr_resp_done && !wr_data_done) begin
            wr_pkt_cnt <= wr_pkt_cnt - 1'b1;
        end
    end

    always_ff @(posedge s_axi_aclk or posedge s_axi_areset) begin
        if (s_axi_areset) begin
            bresp_state  <= hbmc_pkg::BRESP_IDLE;
            s_axi_bvalid <= 1'b0;
        end else begin
            case (bresp_state)
                hbmc_pkg::BRESP_IDLE: begin
                    if (wr_addr_done) begin
                        s_axi_bvalid <= 1'b1;   // data already complete
                        bresp_state  <= hbmc_pkg::BRESP_SEND;
                    end
                end
                hbmc_pkg::BRESP_SEND: begin
                    if (wr_resp_done) begin
                        s_axi_bvalid <= 1'b0;
                        bresp_state  <= hbmc_pkg::BRESP_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/hbmc_lite_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbmc_defs.svh"

module hbmc_lite_top (
    input  logic                 s_axi_aclk,
    input  logic                 s_axi_areset,
    input  hbmc_pkg::axi_id_t    s_axi_awid,
    input  hbmc_pkg::axi_addr_t  s_axi_awaddr,
    input  hbmc_pkg::axi_len_t   s_axi_awlen,
    input  hbmc_pkg::axi_burst_t s_axi_awburst,
    input  logic                 s_axi_awvalid,
    output logic                 s_axi_awready,
    input  hbmc_pkg::axi_data_t  s_axi_wdata,
    input  hbmc_pkg::axi_strb_t  s_axi_wstrb,
    input  logic                 s_axi_wlast,
    input  logic                 s_axi_wvalid,
    output logic                 s_axi_wready,
    output hbmc_pkg::axi_id_t    s_axi_bid,
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,
    input  hbmc_pkg::axi_id_t    s_axi_arid,
    input  hbmc_pkg::axi_addr_t  s_axi_araddr,
    input  hbmc_pkg::axi_len_t   s_axi_arlen,
    input  hbmc_pkg::axi_burst_t s_axi_arburst,
    input  logic                 s_axi_arvalid,
    output logic                 s_axi_arready,
    output hbmc_pkg::axi_id_t    s_axi_rid,
    output hbmc_pkg::axi_data_t  s_axi_rdata,
    output logic [1:0]           s_axi_rresp,
    output logic                 s_axi_rlast,
    output logic                 s_axi_rvalid,
    input  logic                 s_axi_rready
);

    localparam int DFIFO_W = `HBMC_AXI_DATA_WIDTH * 9 / 8;   // data plus strobes
    localparam int UFIFO_W = `HBMC_AXI_DATA_WIDTH + 1;       // data plus last

    logic cmd_req, cmd_wr_not_rd, cmd_wrap_not_incr, cmd_ack;
    hbmc_pkg::mem_addr_t cmd_mem_addr;
    hbmc_pkg::word_cnt_t cmd_word_cnt;

    logic [DFIFO_W-1:0] dfifo_dout;
    logic [UFIFO_W-1:0] ufifo_din, ufifo_dout;
    logic dfifo_full, dfifo_empty, dfifo_pop, ufifo_full, ufifo_empty, ufifo_push;

    logic [`HBMC_LANE_ADDR_WIDTH-1:0] lane_addr;
    logic [1:0]                       lane_we;
    hbmc_pkg::mem_word_t              lane_wdata, lane_rdata;

    assign s_axi_wready = ~dfifo_full;
    assign s_axi_rvalid = ~ufifo_empty;
    assign s_axi_rlast  = ufifo_dout[UFIFO_W-1];
    assign s_axi_rdata  = ufifo_dout[UFIFO_W-2:0];

    hbmc_axi_front u_front (
        .s_axi_aclk, .s_axi_areset,
        .s_axi_awid, .s_axi_awaddr, .s_axi_awlen, .s_axi_awburst, .s_axi_awvalid,
        .s_axi_awready, .s_axi_wvalid, .s_axi_wready, .s_axi_wlast,
        .s_axi_bid, .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .s_axi_arid, .s_axi_araddr, .s_axi_arlen, .s_axi_arburst, .s_axi_arvalid,
        .s_axi_arready, .s_axi_rid, .s_axi_rresp, .s_axi_rlast, .s_axi_rvalid,
        .s_axi_rready, .cmd_req, .cmd_mem_addr, .cmd_word_cnt, .cmd_wr_not_rd,
        .cmd_wrap_not_incr, .cmd_ack
    );

    hbmc_sync_fifo #(.WIDTH(DFIFO_W)) u_dfifo (
        .s_axi_aclk, .s_axi_areset,
        .push(s_axi_wvalid & s_axi_wready), .din({s_axi_wdata, s_axi_wstrb}),
        .full(dfifo_full), .pop(dfifo_pop), .dout(dfifo_dout), .empty(dfifo_empty)
    );

    hbmc_sync_fifo #(.WIDTH(UFIFO_W)) u_ufifo (
        .s_axi_aclk, .s_axi_areset,
        .push(ufifo_push), .din(ufifo_din), .full(ufifo_full),
        .pop(s_axi_rvalid & s_axi_rready), .dout(ufifo_dout), .empty(ufifo_empty)
    );

    hbmc_word_engine u_engine (
        .s_axi_aclk, .s_axi_areset,
        .cmd_req, .cmd_mem_addr, .cmd_word_cnt, .cmd_wr_not_rd, .cmd_wrap_not_incr,
        .cmd_ack, .dfifo_dout, .dfifo_empty, .dfifo_pop, .ufifo_din, .ufifo_full,
        .ufifo_push, .lane_addr, .lane_we, .lane_wdata, .lane_rdata
    );

    // lane 0 holds the low byte of each word
    for (genvar i = 0; i < 2; i++) begin : g_lane
        hbmc_byte_lane u_lane (
            .s_axi_aclk,
            .addr  (lane_addr),
            .we    (lane_we[i]),
            .wdata (lane_wdata[8*i +: 8]),
            .rdata (lane_rdata[8*i +: 8])
        );
    end

endmodule

`default_nettype wire

//--- testbench/tb_hbmc_lite.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hbmc_lite;

    localparam int MEM_BYTES  = 2048;
    localparam int MAX_BEATS  = 16;
    localparam int N_INIT     = MEM_BYTES / (4 * MAX_BEATS);   // bursts to fill the memory
    localparam int N_RAND     = 30;
    localparam int N_WRAP_REP = 2;
    localparam int N_CONC     = 4;
    localparam int NUM_BURSTS = N_INIT + 2 * N_RAND + 12 * N_WRAP_REP + 3 * N_CONC;
    localparam int CYCLE_LIMIT = NUM_BURSTS * MAX_BEATS * 12;   // generous per-beat budget

    logic                 s_axi_aclk, s_axi_areset;
    hbmc_pkg::axi_id_t    s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
    hbmc_pkg::axi_addr_t  s_axi_awaddr, s_axi_araddr;
    hbmc_pkg::axi_len_t   s_axi_awlen, s_axi_arlen;
    hbmc_pkg::axi_burst_t s_axi_awburst, s_axi_arburst;
    hbmc_pkg::axi_data_t  s_axi_wdata, s_axi_rdata;
    hbmc_pkg::axi_strb_t  s_axi_wstrb;
    logic [1:0]           s_axi_bresp, s_axi_rresp;
    logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
    logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic s_axi_rlast, s_axi_rvalid, s_axi_rready;

    logic [7:0]  model_mem  [0:MEM_BYTES-1];   // reference byte memory
    logic [31:0] wbeat_data [0:MAX_BEATS-1];   // beats of the write in flight
    logic [3:0]  wbeat_strb [0:MAX_BEATS-1];
    int err_cnt;
    int check_cnt;
    int cycle_cnt;

    hbmc_lite_top DUT (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #50 s_axi_aclk = ~s_axi_aclk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge s_axi_aclk);
            cycle_cnt++;
        end
        $display("ERROR: run did not complete within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // byte address of beat i folded into the 2 KiB memory
    function automatic int beat_addr(input logic [31:0] addr, input int len,
                                     input bit is_wrap, input int i);
        logic [31:0] base;
        logic [31:0] blk_mask;
        logic [31:0] a;
        base     = addr & ~32'h3;
        blk_mask = 32'((len + 1) * 4 - 1);
        if (is_wrap) begin
            a = (base & ~blk_mask) | ((base + 32'(4 * i)) & blk_mask);   // stay inside block
        end else begin
            a = base + 32'(4 * i);
        end
        return int'(a & 32'(MEM_BYTES - 1));
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] want, input string what);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("CHECK FAILED @ %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, what, got, want);
        end
    endtask

    task automatic step();
        @(posedge s_axi_aclk);
        #1;
    endtask

    task automatic send_wdata(input int len, input bit full_strb);
        for (int i = 0; i <= len; i++) begin
            wbeat_data[i] = $urandom;
            wbeat_strb[i] = full_strb ? 4'hf : 4'($urandom);
            s_axi_wdata  = wbeat_data[i];
            s_axi_wstrb  = wbeat_strb[i];
            s_axi_wlast  = (i == len);
            s_axi_wvalid = 1'b1;
            @(negedge s_axi_aclk);
            while (!s_axi_wready) begin
                @(negedge s_axi_aclk);
            end
            step();
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
    endtask

    task automatic write_addr_resp(input int id, input logic [31:0] addr, input int len,
                                   input bit is_wrap);
        int delay;
        int a;
        s_axi_awid    = hbmc_pkg::axi_id_t'(id);
        s_axi_awaddr  = addr;
        s_axi_awlen   = hbmc_pkg::axi_len_t'(len);
        s_axi_awburst = is_wrap ? hbmc_pkg::BURST_WRAP : hbmc_pkg::BURST_INCR;
        s_axi_awvalid = 1'b1;
        @(negedge s_axi_aclk);
        while (!s_axi_awready) begin
            @(negedge s_axi_aclk);
        end
        step();
        s_axi_awvalid = 1'b0;
        check_val(32'(s_axi_bvalid), 32'd1, "bvalid one cycle after AW transfer");
        delay = $urandom_range(0, 5);
        repeat (delay) begin
            step();
            check_val(32'(s_axi_bvalid), 32'd1, "bvalid held while bready low");
        end
        s_axi_bready = 1'b1;
        check_val(32'(s_axi_bid), 32'(id), "bid echoes awid");
        check_val(32'(s_axi_bresp), 32'(hbmc_pkg::RESP_OKAY), "bresp");
        step();
        s_axi_bready = 1'b0;
        for (int i = 0; i <= len; i++) begin
            a = beat_addr(addr, len, is_wrap, i);
            for (int b = 0; b < 4; b++) begin
                if (wbeat_strb[i][b]) begin
                    model_mem[(a + b) & (MEM_BYTES - 1)] = wbeat_data[i][8*b +: 8];
                end
            end
        end
    endtask

    task automatic read_burst(input int id, input logic [31:0] addr, input int len,
                              input bit is_wrap);
        int beat;
        int a;
        logic [31:0] want;
        s_axi_arid    = hbmc_pkg::axi_id_t'(id);
        s_axi_araddr  = addr;
        s_axi_arlen   = hbmc_pkg::axi_len_t'(len);
        s_axi_arburst = is_wrap ? hbmc_pkg::BURST_WRAP : hbmc_pkg::BURST_INCR;
        s_axi_arvalid = 1'b1;
        @(negedge s_axi_aclk);
        while (!s_axi_arready) begin
            @(negedge s_axi_aclk);
        end
        step();
        s_axi_arvalid = 1'b0;
        beat = 0;
        while (beat <= len) begin
            s_axi_rready = ($urandom_range(0, 3) != 0);   // random back-pressure
            @(negedge s_axi_aclk);
            if (s_axi_rvalid && s_axi_rready) begin
                a = beat_addr(addr, len, is_wrap, beat);
                for (int b = 0; b < 4; b++) begin
                    want[8*b +: 8] = model_mem[(a + b) & (MEM_BYTES - 1)];
                end
                check_val(s_axi_rdata, want,
                          $sformatf("rdata beat %0d of read at 0x%08h", beat, addr));
                check_val(32'(s_axi_rlast), 32'(beat == len), "rlast on final beat only");
                check_val(32'(s_axi_rid), 32'(id), "rid echoes arid");
                check_val(32'(s_axi_rresp), 32'(hbmc_pkg::RESP_OKAY), "rresp");
                beat++;
            end
            step();
        end
        s_axi_rready = 1'b0;
    endtask

    initial begin
        int len;
        int rlen;
        logic [31:0] addr;
        logic [31:0] raddr;
        logic [31:0] blk_mask;
        void'($urandom(16));
        err_cnt       = 0;
        check_cnt     = 0;
        s_axi_areset  = 1'b1;
        s_axi_awid    = '0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awburst = hbmc_pkg::BURST_INCR;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arburst = hbmc_pkg::BURST_INCR;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (8) @(posedge s_axi_aclk);
        #1;
        s_axi_areset = 1'b0;
        check_val(32'(s_axi_awready), 32'd0, "awready after reset");
        check_val(32'(s_axi_arready), 32'd0, "arready after reset");
        check_val(32'(s_axi_bvalid), 32'd0, "bvalid after reset");
        check_val(32'(s_axi_rvalid), 32'd0, "rvalid after reset");
        check_val(32'(s_axi_wready), 32'd1, "wready after reset");

        for (int k = 0; k < N_INIT; k++) begin   // known contents everywhere
            send_wdata(MAX_BEATS - 1, 1'b1);
            write_addr_resp(k % 16, 32'(k * 4 * MAX_BEATS), MAX_BEATS - 1, 1'b0);
        end

        for (int k = 0; k < N_RAND; k++) begin
            addr = $urandom & ~32'h3;
            len  = $urandom_range(0, MAX_BEATS - 1);
            send_wdata(len, 1'b0);
            write_addr_resp($urandom_range(0, 15), addr, len, 1'b0);
            read_burst($urandom_range(0, 15), addr, len, 1'b0);
        end

        for (int r = 0; r < N_WRAP_REP; r++) begin
            for (int j = 0; j < 4; j++) begin
                len      = (2 << j) - 1;   // 1, 3, 7, 15
                blk_mask = 32'((len + 1) * 4 - 1);
                addr     = $urandom & ~32'h3;
                if ((addr & blk_mask) == 32'd0) begin
                    addr = addr + 32'd4;   // force a mid-block start
                end
                send_wdata(len, 1'b0);
                write_addr_resp($urandom_range(0, 15), addr, len, 1'b1);
                read_burst($urandom_range(0, 15), addr, len, 1'b1);
                read_burst($urandom_range(0, 15), addr & ~blk_mask, len, 1'b0);
            end
        end

        for (int k = 0; k < N_CONC; k++) begin
            len   = $urandom_range(0, MAX_BEATS - 1);
            rlen  = $urandom_range(0, MAX_BEATS - 1);
            addr  = 32'($urandom_range(0, 239)) * 32'd4;          // lower KiB
            raddr = 32'd1024 + 32'($urandom_range(0, 239)) * 32'd4;   // upper KiB
            send_wdata(len, 1'b0);
            fork
                write_addr_resp(k, addr, len, 1'b0);
                read_burst(k + 8, raddr, rlen, 1'b0);
            join
            read_burst(k + 4, addr, len, 1'b0);
        end

        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hbmc_lite.f
+incdir+include
logic/hbmc_pkg.sv
logic/hbmc_byte_lane.sv
logic/hbmc_sync_fifo.sv
logic/hbmc_word_engine.sv
logic/hbmc_axi_front.sv
logic/hbmc_lite_top.sv
testbench/tb_hbmc_lite.sv

//--- Makefile
# Verilator build and run for hbmc_lite

VERILATOR ?= verilator
TOP       ?= tb_hbmc_lite
FILELIST  ?= hbmc_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := include/hbmc_defs.svh $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
